// ==== src.f ====
obj_pkg.sv
obj_hit_if.sv
obj_regs.sv
obj_scan.sv
obj_fetch.sv
obj_line_buf.sv
obj_top.sv
tb_clock.sv
tb_obj_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_obj_top
FLAGS     ?= --binary --timing
BUILD_DIR ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f src.f
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "Simulation finished: PASS"

clean:
	rm -rf $(BUILD_DIR)

// ==== tb_obj_top.sv ====
`timescale 1ns/1ns

module tb_obj_top;

   // Shallow hit queue so a full line stalls the scanner
   localparam int OBJ_CREDITS  = 2;
   localparam int OBJ_PER_LINE = 8;
   localparam int LINE_TIMEOUT = 3000;
   localparam int RST_TIMEOUT  = 20;
   localparam logic [15:0] LFSR_SEED = 16'd4070;

   logic       CLK_12M;
   logic       RST_4L;
   logic       cpu_we;
   logic       cpu_re;
   logic [9:0] cpu_addr;
   logic [7:0] cpu_wdata;
   logic [7:0] cpu_rdata;
   logic       line_start;
   logic [7:0] line_num;
   logic       line_done;
   logic       pix_rd;
   logic [7:0] pix_x;
   logic [3:0] pix_out;

   // Shadow copies of everything the CPU wrote
   logic [7:0] attr_sh [256];
   logic [7:0] pat_sh  [512];
   logic [7:0] ctrl_sh;

   // Expected front line and the line now building
   logic [3:0] exp_cur  [256];
   logic [3:0] exp_next [256];

   logic [15:0] lfsr_state;
   int          errors;
   int          test_start_err;
   int          tests_run;
   int          tests_failed;
   int          done_count;
   logic        chk_valid;
   logic [7:0]  chk_x;

   tb_clock u_tb_clock (
      .CLK_12M (CLK_12M),
      .RST_4L  (RST_4L)
   );

   obj_top #(
      .OBJ_CREDITS  (OBJ_CREDITS),
      .OBJ_PER_LINE (OBJ_PER_LINE)
   ) u_obj_top (
      .CLK_12M    (CLK_12M),
      .RST_4L     (RST_4L),
      .cpu_we     (cpu_we),
      .cpu_re     (cpu_re),
      .cpu_addr   (cpu_addr),
      .cpu_wdata  (cpu_wdata),
      .cpu_rdata  (cpu_rdata),
      .line_start (line_start),
      .line_num   (line_num),
      .line_done  (line_done),
      .pix_rd     (pix_rd),
      .pix_x      (pix_x),
      .pix_out    (pix_out)
   );

   // --------------------
   // Random source
   // --------------------

   // Taps 16, 14, 13, 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // One LFSR step per bit taken
   function logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int k = 0; k < n; k++)
      begin
         lfsr_state = lfsr_next(lfsr_state);
         r = {r[30:0], lfsr_state[0]};
      end
      return r;
   endfunction

   // --------------------
   // Reference line
   // --------------------
   function void build_expected(input logic [7:0] l);
      logic [7:0] lt;
      logic [7:0] row;
      logic [7:0] at;
      logic [7:0] p0;
      logic [7:0] p1;
      logic [1:0] v;
      int         cnt;
      int         base;
      int         b;
      int         pos;
      for (int p = 0; p < 256; p++)
         exp_next[p] = 4'h0;
      if (!ctrl_sh[0])
         return;
      // Screen flip tests coverage against 255 - L
      lt  = ctrl_sh[1] ? 8'(255 - int'(l)) : l;
      cnt = 0;
      for (int n = 0; n < 64; n++)
      begin
         row = lt - attr_sh[4 * n];
         if (row < 8'd8 && cnt < OBJ_PER_LINE)
         begin
            cnt++;
            at = attr_sh[4 * n + 2];
            if (at[6])
               row = 8'd7 - row;
            base = 16 * int'(attr_sh[4 * n + 1][4:0]) + 2 * int'(row);
            p0   = pat_sh[base];
            p1   = pat_sh[base + 1];
            for (int i = 0; i < 8; i++)
            begin
               b   = at[7] ? i : 7 - i;
               v   = {p1[b], p0[b]};
               pos = int'(attr_sh[4 * n + 3]) + i;
               // Past the right edge is dropped
               if (pos <= 255)
               begin
                  if (ctrl_sh[1])
                     pos = 255 - pos;
                  if (v != 2'b00 && exp_next[pos] == 4'h0)
                     exp_next[pos] = {at[1:0], v};
               end
            end
         end
      end
   endfunction

   // --------------------
   // Compare process
   // --------------------
   always @(posedge CLK_12M)
   begin
      chk_valid <= pix_rd;
      chk_x     <= pix_x;
      if (line_done)
         done_count <= done_count + 1;
   end

   // pix_out is stable at the falling edge
   always @(negedge CLK_12M)
   begin
      if (chk_valid)
      begin
         assert (pix_out == exp_cur[chk_x])
         else
         begin
            $display("MISMATCH time=%0t signal=pix_out x=%0d expected=%h actual=%h",
                     $time, chk_x, exp_cur[chk_x], pix_out);
            errors++;
         end
      end
   end

   // --------------------
   // CPU access
   // --------------------
   task automatic cpu_write(input logic [9:0] addr, input logic [7:0] data);
      @(negedge CLK_12M);
      cpu_we    = 1'b1;
      cpu_addr  = addr;
      cpu_wdata = data;
      @(negedge CLK_12M);
      cpu_we = 1'b0;
      if (addr[9])
         pat_sh[addr[8:0]] = data;
      else if (addr[9:8] == 2'b00)
         attr_sh[addr[7:0]] = data;
      else if (addr == 10'h100)
         ctrl_sh = data;
   endtask

   task automatic cpu_read_check(input logic [9:0] addr);
      logic [7:0] expv;
      if (addr[9])
         expv = pat_sh[addr[8:0]];
      else if (addr[9:8] == 2'b00)
         expv = attr_sh[addr[7:0]];
      else if (addr == 10'h100)
         expv = ctrl_sh;
      else
         expv = 8'h00;
      @(negedge CLK_12M);
      cpu_re   = 1'b1;
      cpu_addr = addr;
      @(negedge CLK_12M);
      cpu_re = 1'b0;
      assert (cpu_rdata == expv)
      else
      begin
         $display("MISMATCH time=%0t signal=cpu_rdata addr=%h expected=%h actual=%h",
                  $time, addr, expv, cpu_rdata);
         errors++;
      end
   endtask

   task automatic write_object(input int n, input logic [7:0] y, input logic [7:0] code,
                               input logic [7:0] at, input logic [7:0] x);
      cpu_write(10'(4 * n), y);
      cpu_write(10'(4 * n + 1), code);
      cpu_write(10'(4 * n + 2), at);
      cpu_write(10'(4 * n + 3), x);
   endtask

   // Park every entry on lines 240 to 247, never used by the directed tests
   task automatic clear_objects();
      for (int n = 0; n < 64; n++)
         cpu_write(10'(4 * n), 8'hF0);
   endtask

   // --------------------
   // Line build and readout
   // --------------------
   task automatic run_line(input logic [7:0] l);
      int target;
      int waited;
      build_expected(l);
      target = done_count;
      @(negedge CLK_12M);
      line_start = 1'b1;
      line_num   = l;
      // Swapped front holds the previous build
      for (int x = 0; x < 256; x++)
      begin
         @(negedge CLK_12M);
         line_start = 1'b0;
         pix_rd     = 1'b1;
         pix_x      = 8'(x);
      end
      @(negedge CLK_12M);
      pix_rd = 1'b0;
      @(negedge CLK_12M);
      waited = 0;
      while (done_count <= target && waited < LINE_TIMEOUT)
      begin
         @(negedge CLK_12M);
         waited++;
      end
      if (done_count <= target)
      begin
         $display("Timeout: line_done never came for line %0d", l);
         $display("Simulation finished: FAIL");
         $finish;
      end
      for (int p = 0; p < 256; p++)
         exp_cur[p] = exp_next[p];
   endtask

   task automatic end_test(input string name);
      // Flush so the last built line is checked inside this test
      run_line(8'd0);
      tests_run++;
      if (errors != test_start_err)
         tests_failed++;
      $display("Test %0d %s: %s (%0d errors)", tests_run, name,
               (errors == test_start_err) ? "ok" : "failed", errors - test_start_err);
      test_start_err = errors;
   endtask

   // --------------------
   // Stimulus
   // --------------------
   initial
   begin
      int          waited;
      logic [1:0]  kind;
      logic [9:0]  addr;
      logic [7:0]  l;
      logic [7:0]  x;
      cpu_we         = 1'b0;
      cpu_re         = 1'b0;
      cpu_addr       = '0;
      cpu_wdata      = '0;
      line_start     = 1'b0;
      line_num       = '0;
      pix_rd         = 1'b0;
      pix_x          = '0;
      errors         = 0;
      test_start_err = 0;
      tests_run      = 0;
      tests_failed   = 0;
      done_count     = 0;
      chk_valid      = 1'b0;
      lfsr_state     = LFSR_SEED;
      ctrl_sh        = 8'h00;
      // RAM contents after reset are unknown, so tests 2 to 4 write what they use
      for (int i = 0; i < 256; i++)
      begin
         attr_sh[i] = 8'h00;
         exp_cur[i] = 4'h0;
      end
      for (int i = 0; i < 512; i++)
         pat_sh[i] = 8'h00;

      waited = 0;
      while (RST_4L !== 1'b1 && waited < RST_TIMEOUT)
      begin
         @(negedge CLK_12M);
         waited++;
      end
      if (RST_4L !== 1'b1)
      begin
         $display("Timeout: reset was never released");
         $display("Simulation finished: FAIL");
         $finish;
      end

      // Test 1, empty lines after reset, then readback
      run_line(8'd10);
      run_line(8'd11);
      for (int k = 0; k < 60; k++)
      begin
         kind = 2'(rand_bits(2));
         case (kind)
            2'd2: addr = 10'h100;
            2'd3: addr = {1'b1, 9'(rand_bits(9))};
            default: addr = {2'b00, 8'(rand_bits(8))};
         endcase
         cpu_write(addr, 8'(rand_bits(8)));
         cpu_read_check(addr);
      end
      cpu_read_check(10'h180);
      // Engine off before the flush line builds
      cpu_write(10'h100, 8'h00);
      end_test("readback");

      // Test 2, one object through all flips and rows
      clear_objects();
      for (int k = 0; k < 16; k++)
         cpu_write(10'(10'h200 + 16 * 3 + k), 8'(rand_bits(8)));
      for (int f = 0; f < 8; f++)
      begin
         cpu_write(10'h100, {6'd0, f[2], 1'b1});
         for (int r = 0; r < 8; r++)
         begin
            x = (r >= 6) ? 8'(240 + 2 * r) : 8'(30 + 20 * r);
            write_object(0, 8'd100, 8'd3, {f[0], f[1], 4'd0, 2'(r)}, x);
            l = f[2] ? 8'(255 - (100 + r)) : 8'(100 + r);
            run_line(l);
         end
      end
      end_test("single object");

      // Test 3, lower index wins, transparent pixels show through
      cpu_write(10'h100, 8'h01);
      for (int r = 0; r < 8; r++)
      begin
         cpu_write(10'(10'h210 + 2 * r), 8'hAA);
         cpu_write(10'(10'h211 + 2 * r), 8'h0F);
         cpu_write(10'(10'h220 + 2 * r), 8'hFF);
         cpu_write(10'(10'h221 + 2 * r), 8'hFF);
      end
      write_object(0, 8'd60, 8'd1, 8'h01, 8'd50);
      write_object(1, 8'd60, 8'd2, 8'h02, 8'd52);
      for (int r = 0; r < 8; r++)
         run_line(8'(60 + r));
      end_test("priority");

      // Test 4, ten objects on one line with the queue filling
      clear_objects();
      for (int n = 0; n < 10; n++)
         write_object(n, 8'd120, 8'd2, 8'(n % 4), 8'(n * 20));
      for (int r = 0; r < 8; r++)
         run_line(8'(120 + r));
      end_test("line limit");

      // Test 5, random scenes then disabled
      for (int i = 0; i < 256; i++)
         cpu_write(10'(i), 8'(rand_bits(8)));
      for (int i = 0; i < 512; i++)
         cpu_write(10'(10'h200 + i), 8'(rand_bits(8)));
      for (int k = 0; k < 16; k++)
      begin
         cpu_write(10'h100, {6'd0, 1'(rand_bits(1)), 1'b1});
         run_line(8'(rand_bits(8)));
      end
      cpu_write(10'h100, 8'h00);
      for (int k = 0; k < 4; k++)
         run_line(8'(rand_bits(8)));
      end_test("random scenes");

      $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
      if (errors == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/1ns

// 100 ns clock, reset held low for the first two rising edges
module tb_clock (
   output logic CLK_12M,
   output logic RST_4L
);

   initial
   begin
      CLK_12M = 1'b0;
      forever #50 CLK_12M = ~CLK_12M;
   end

   initial
   begin
      RST_4L = 1'b0;
      repeat (2) @(posedge CLK_12M);
      @(negedge CLK_12M);
      RST_4L = 1'b1;
   end

endmodule

// ==== obj_top.sv ====
`timescale 1ns/1ns

module obj_top
   import obj_pkg::*;
#(
   parameter int OBJ_CREDITS  = 4,
   parameter int OBJ_PER_LINE = 8
)
(
   input  logic       CLK_12M,
   input  logic       RST_4L,
   // CPU side
   input  logic       cpu_we,
   input  logic       cpu_re,
   input  cpu_addr_t  cpu_addr,
   input  cpu_data_t  cpu_wdata,
   output cpu_data_t  cpu_rdata,
   // Line build
   input  logic       line_start,
   input  obj_pos_t   line_num,
   output logic       line_done,
   // Display readout
   input  logic       pix_rd,
   input  obj_pos_t   pix_x,
   output obj_pixel_t pix_out
);

   logic [7:0] attr_addr;
   cpu_data_t  attr_data;
   logic [8:0] pat_addr;
   cpu_data_t  pat_data;
   logic       obj_enable;
   logic       screen_flip;
   logic       scan_done;
   logic       buf_we;
   obj_pos_t   buf_pos;
   obj_pixel_t buf_pix;

   // Scanner to fetcher hits and credits
   obj_hit_if u_hit_if ();

   obj_regs u_obj_regs (
      .CLK_12M     (CLK_12M),
      .RST_4L      (RST_4L),
      .cpu_we      (cpu_we),
      .cpu_re      (cpu_re),
      .cpu_addr    (cpu_addr),
      .cpu_wdata   (cpu_wdata),
      .cpu_rdata   (cpu_rdata),
      .attr_addr   (attr_addr),
      .attr_data   (attr_data),
      .pat_addr    (pat_addr),
      .pat_data    (pat_data),
      .obj_enable  (obj_enable),
      .screen_flip (screen_flip)
   );

   obj_scan #(
      .OBJ_CREDITS  (OBJ_CREDITS),
      .OBJ_PER_LINE (OBJ_PER_LINE)
   ) u_obj_scan (
      .CLK_12M     (CLK_12M),
      .RST_4L      (RST_4L),
      .line_start  (line_start),
      .line_num    (line_num),
      .obj_enable  (obj_enable),
      .screen_flip (screen_flip),
      .attr_addr   (attr_addr),
      .attr_data   (attr_data),
      .hit         (u_hit_if.scan),
      .scan_done   (scan_done)
   );

   obj_fetch #(
      .OBJ_CREDITS (OBJ_CREDITS)
   ) u_obj_fetch (
      .CLK_12M     (CLK_12M),
      .RST_4L      (RST_4L),
      .hit         (u_hit_if.fetch),
      .scan_done   (scan_done),
      .screen_flip (screen_flip),
      .pat_addr    (pat_addr),
      .pat_data    (pat_data),
      .buf_we      (buf_we),
      .buf_pos     (buf_pos),
      .buf_pix     (buf_pix),
      .line_done   (line_done)
   );

   obj_line_buf u_obj_line_buf (
      .CLK_12M    (CLK_12M),
      .RST_4L     (RST_4L),
      .line_start (line_start),
      .buf_we     (buf_we),
      .buf_pos    (buf_pos),
      .buf_pix    (buf_pix),
      .pix_rd     (pix_rd),
      .pix_x      (pix_x),
      .pix_out    (pix_out)
   );

endmodule

// ==== obj_line_buf.sv ====
`timescale 1ns/1ns

module obj_line_buf
   import obj_pkg::*;
(
   input  logic       CLK_12M,
   input  logic       RST_4L,
   input  logic       line_start,
   input  logic       buf_we,
   input  obj_pos_t   buf_pos,
   input  obj_pixel_t buf_pix,
   input  logic       pix_rd,
   input  obj_pos_t   pix_x,
   output obj_pixel_t pix_out
);

   // Two line buffers, front read by display, back built by fetcher
   obj_pixel_t line_mem [2][256];
   // Front buffer select
   logic       front;

   // --------------------
   // Swap, write and clear-on-read
   // --------------------
   always_ff @(posedge CLK_12M or negedge RST_4L)
   begin
      if (!RST_4L)
      begin
         front   <= 1'b0;
         pix_out <= '0;
         for (int b = 0; b < 2; b++)
         begin
            for (int p = 0; p < 256; p++)
               line_mem[b][p] <= '0;
         end
      end
      else
      begin
         if (line_start)
            front <= ~front;
         // Opaque pixel into an empty slot only, first writer keeps it
         if (buf_we && (buf_pix[1:0] != 2'b00) && (line_mem[~front][buf_pos] == '0))
            line_mem[~front][buf_pos] <= buf_pix;
         // Display read empties the slot for the next build
         if (pix_rd)
         begin
            pix_out               <= line_mem[front][pix_x];
            line_mem[front][pix_x] <= '0;
         end
      end
   end

endmodule

// ==== obj_fetch.sv ====
`timescale 1ns/1ns

module obj_fetch
   import obj_pkg::*;
#(
   parameter int OBJ_CREDITS = 4
)
(
   input  logic       CLK_12M,
   input  logic       RST_4L,
   obj_hit_if.fetch   hit,
   input  logic       scan_done,
   input  logic       screen_flip,
   output logic [8:0] pat_addr,
   input  cpu_data_t  pat_data,
   output logic       buf_we,
   output obj_pos_t   buf_pos,
   output obj_pixel_t buf_pix,
   output logic       line_done
);

   localparam int PTR_W = (OBJ_CREDITS > 1) ? $clog2(OBJ_CREDITS) : 1;
   localparam int CNT_W = $clog2(OBJ_CREDITS + 1);

   // --------------------
   // Hit queue
   // --------------------
   obj_code_t  q_code  [OBJ_CREDITS];
   obj_row_t   q_row   [OBJ_CREDITS];
   obj_pos_t   q_x     [OBJ_CREDITS];
   logic [1:0] q_color [OBJ_CREDITS];
   logic       q_xflip [OBJ_CREDITS];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] q_count;
   logic             pop;

   fetch_state_t state;
   obj_code_t    cur_code;
   obj_row_t     cur_row;
   obj_pos_t     cur_x;
   logic [1:0]   cur_color;
   logic         cur_xflip;
   cpu_data_t    plane0_q;
   obj_row_t     pix_i;
   obj_row_t     bit_sel;
   logic [8:0]   draw_sum;
   logic         seen_done;

   function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(OBJ_CREDITS - 1))
         return '0;
      return ptr + 1'b1;
   endfunction

   assign pop = (state == FETCH_IDLE) && (q_count != '0);

   // Plane 1 address held through the draw so pat_data keeps plane 1
   assign pat_addr = {cur_code, cur_row, (state == FETCH_PLANE1) || (state == FETCH_DRAW)};

   // Leftmost pixel is bit 7 unless flipped
   assign bit_sel  = cur_xflip ? pix_i : ~pix_i;
   // Bit 8 set means past the right edge
   assign draw_sum = {1'b0, cur_x} + {6'd0, pix_i};

   always_ff @(posedge CLK_12M or negedge RST_4L)
   begin
      if (!RST_4L)
      begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         q_count    <= '0;
         state      <= FETCH_IDLE;
         pix_i      <= '0;
         hit.credit <= 1'b0;
         buf_we     <= 1'b0;
         seen_done  <= 1'b0;
         line_done  <= 1'b0;
      end
      else
      begin
         if (hit.hit_valid)
            wr_ptr <= ptr_next(wr_ptr);
         if (pop)
            rd_ptr <= ptr_next(rd_ptr);
         case ({hit.hit_valid, pop})
            2'b10: q_count <= q_count + 1'b1;
            2'b01: q_count <= q_count - 1'b1;
            default: ;
         endcase
         // Each pop frees a slot for the scanner
         hit.credit <= pop;
         buf_we     <= (state == FETCH_DRAW) && !draw_sum[8];

         case (state)
            FETCH_IDLE:
               if (pop)
                  state <= FETCH_PLANE0;
            FETCH_PLANE0:
               state <= FETCH_PLANE1;
            FETCH_PLANE1:
            begin
               pix_i <= '0;
               state <= FETCH_DRAW;
            end
            default:
            begin
               pix_i <= pix_i + 1'b1;
               if (&pix_i)
                  state <= FETCH_IDLE;
            end
         endcase

         // Line ends when scan is over and nothing is left to draw
         line_done <= 1'b0;
         if (scan_done)
            seen_done <= 1'b1;
         else if (seen_done && (state == FETCH_IDLE) && (q_count == '0) && !hit.hit_valid)
         begin
            seen_done <= 1'b0;
            line_done <= 1'b1;
         end
      end
   end

   // Queue storage, current object and pixel payload
   always_ff @(posedge CLK_12M)
   begin
      if (hit.hit_valid)
      begin
         q_code[wr_ptr]  <= hit.hit_code;
         q_row[wr_ptr]   <= hit.hit_row;
         q_x[wr_ptr]     <= hit.hit_x;
         q_color[wr_ptr] <= hit.hit_color;
         q_xflip[wr_ptr] <= hit.hit_xflip;
      end
      if (pop)
      begin
         cur_code  <= q_code[rd_ptr];
         cur_row   <= q_row[rd_ptr];
         cur_x     <= q_x[rd_ptr];
         cur_color <= q_color[rd_ptr];
         cur_xflip <= q_xflip[rd_ptr];
      end
      // Plane 0 data lands while plane 1 is addressed
      if (state == FETCH_PLANE1)
         plane0_q <= pat_data;
      buf_pos <= screen_flip ? ~draw_sum[7:0] : draw_sum[7:0];
      buf_pix <= {cur_color, pat_data[bit_sel], plane0_q[bit_sel]};
   end

endmodule

// ==== obj_scan.sv ====
`timescale 1ns/1ns

module obj_scan
   import obj_pkg::*;
#(
   parameter int OBJ_CREDITS  = 4,
   parameter int OBJ_PER_LINE = 8
)
(
   input  logic       CLK_12M,
   input  logic       RST_4L,
   input  logic       line_start,
   input  obj_pos_t   line_num,
   input  logic       obj_enable,
   input  logic       screen_flip,
   output logic [7:0] attr_addr,
   input  cpu_data_t  attr_data,
   obj_hit_if.scan    hit,
   output logic       scan_done
);

   localparam int CRD_W = $clog2(OBJ_CREDITS + 1);
   localparam int CNT_W = $clog2(OBJ_PER_LINE + 1);

   scan_state_t      state;
   obj_index_t       idx;
   // Byte within the entry: 0 Y, 1 code, 2 attribute, 3 X
   logic [1:0]       sel;
   obj_pos_t         line_q;
   logic [CRD_W-1:0] credits;
   logic [CNT_W-1:0] hit_cnt;
   obj_pos_t         diff;
   logic             covers;
   logic             send;
   logic             advance;

   // Saved fields of the entry being read
   obj_row_t   row_q;
   obj_code_t  code_q;
   logic [1:0] color_q;
   logic       xflip_q;

   assign attr_addr = {idx, sel};
   assign scan_done = (state == SCAN_DONE);

   // Row of the object on this line, wraps mod 256
   assign diff   = line_q - attr_data;
   assign covers = obj_enable && (diff[7:3] == 5'd0) && (hit_cnt < CNT_W'(OBJ_PER_LINE));
   // X byte on the bus and a credit in hand
   assign send    = (state == SCAN_TEST) && (sel == 2'd3) && (credits != '0);
   // Leave this entry, either missed or sent
   assign advance = ((state == SCAN_TEST) && (sel == 2'd0) && !covers) || send;

   // --------------------
   // Entry walk
   // --------------------
   always_ff @(posedge CLK_12M or negedge RST_4L)
   begin
      if (!RST_4L)
      begin
         state         <= SCAN_IDLE;
         idx           <= '0;
         sel           <= '0;
         line_q        <= '0;
         hit_cnt       <= '0;
         hit.hit_valid <= 1'b0;
      end
      else
      begin
         hit.hit_valid <= send;
         if (send)
            hit_cnt <= hit_cnt + 1'b1;
         case (state)
            SCAN_IDLE:
               if (line_start)
               begin
                  // Screen flip tests against 255 - L
                  line_q  <= screen_flip ? ~line_num : line_num;
                  idx     <= '0;
                  sel     <= '0;
                  hit_cnt <= '0;
                  state   <= SCAN_READ;
               end
            // Address out, data arrives next cycle
            SCAN_READ:
               state <= SCAN_TEST;
            SCAN_TEST:
               if (advance)
               begin
                  sel <= '0;
                  if (&idx)
                     state <= SCAN_DONE;
                  else
                  begin
                     idx   <= idx + 1'b1;
                     state <= SCAN_READ;
                  end
               end
               else if (sel != 2'd3)
               begin
                  sel   <= sel + 1'b1;
                  state <= SCAN_READ;
               end
            // One-cycle done marker
            default:
               state <= SCAN_IDLE;
         endcase
      end
   end

   // Entry fields and hit payload
   always_ff @(posedge CLK_12M)
   begin
      if (state == SCAN_TEST)
      begin
         case (sel)
            2'd0: row_q  <= diff[2:0];
            2'd1: code_q <= attr_data[4:0];
            2'd2:
            begin
               // Vertical flip, 7 - row
               row_q   <= row_q ^ {3{attr_data[6]}};
               xflip_q <= attr_data[7];
               color_q <= attr_data[1:0];
            end
            default: ;
         endcase
      end
      if (send)
      begin
         hit.hit_code  <= code_q;
         hit.hit_row   <= row_q;
         hit.hit_x     <= attr_data;
         hit.hit_color <= color_q;
         hit.hit_xflip <= xflip_q;
      end
   end

   // Credit count, spent on send, returned by fetcher pops
   always_ff @(posedge CLK_12M or negedge RST_4L)
   begin
      if (!RST_4L)
         credits <= CRD_W'(OBJ_CREDITS);
      else
      begin
         case ({send, hit.credit})
            2'b10: credits <= credits - 1'b1;
            2'b01: credits <= credits + 1'b1;
            default: ;
         endcase
      end
   end

endmodule

// ==== obj_regs.sv ====
`timescale 1ns/1ns

module obj_regs
   import obj_pkg::*;
(
   input  logic       CLK_12M,
   input  logic       RST_4L,
   input  logic       cpu_we,
   input  logic       cpu_re,
   input  cpu_addr_t  cpu_addr,
   input  cpu_data_t  cpu_wdata,
   output cpu_data_t  cpu_rdata,
   input  logic [7:0] attr_addr,
   output cpu_data_t  attr_data,
   input  logic [8:0] pat_addr,
   output cpu_data_t  pat_data,
   output logic       obj_enable,
   output logic       screen_flip
);

   // Object attribute store, 64 entries x 4 bytes
   cpu_data_t attr_ram [256];
   // Two-plane pattern store, 32 codes x 8 rows x 2 planes
   cpu_data_t pat_ram [512];
   cpu_data_t ctrl_reg;

   logic sel_attr;
   logic sel_ctrl;
   logic sel_pat;

   // --------------------
   // Address decode
   // --------------------
   assign sel_attr = (cpu_addr[9:8] == ATTR_BASE[9:8]);
   assign sel_ctrl = (cpu_addr == CTRL_ADDR);
   assign sel_pat  = (cpu_addr[9] == PAT_BASE[9]);

   // --------------------
   // RAM write and engine read ports
   // --------------------
   always_ff @(posedge CLK_12M)
   begin
      if (cpu_we && sel_attr)
         attr_ram[cpu_addr[7:0]] <= cpu_wdata;
      if (cpu_we && sel_pat)
         pat_ram[cpu_addr[8:0]] <= cpu_wdata;
      // Engine data one cycle after the address
      attr_data <= attr_ram[attr_addr];
      pat_data  <= pat_ram[pat_addr];
   end

   // Control register and CPU readback
   always_ff @(posedge CLK_12M or negedge RST_4L)
   begin
      if (!RST_4L)
      begin
         ctrl_reg  <= '0;
         cpu_rdata <= '0;
      end
      else
      begin
         if (cpu_we && sel_ctrl)
            ctrl_reg <= cpu_wdata;
         if (cpu_re)
         begin
            if (sel_pat)
               cpu_rdata <= pat_ram[cpu_addr[8:0]];
            else if (sel_attr)
               cpu_rdata <= attr_ram[cpu_addr[7:0]];
            else if (sel_ctrl)
               cpu_rdata <= ctrl_reg;
            else
               // Hole between control and pattern RAM reads as zero
               cpu_rdata <= '0;
         end
      end
   end

   assign obj_enable  = ctrl_reg[CTRL_EN_BIT];
   assign screen_flip = ctrl_reg[CTRL_FLIP_BIT];

endmodule

// ==== obj_hit_if.sv ====
`timescale 1ns/1ns

// Found objects from scanner to fetcher
// One hit per cycle with hit_valid, credit pulses come back one per pop
interface obj_hit_if
   import obj_pkg::*;
();

   logic       hit_valid;
   obj_code_t  hit_code;
   // Row already vertically flipped
   obj_row_t   hit_row;
   obj_pos_t   hit_x;
   logic [1:0] hit_color;
   logic       hit_xflip;

   // One credit returned per pulse
   logic       credit;

   modport scan (
      output hit_valid, hit_code, hit_row, hit_x, hit_color, hit_xflip,
      input  credit
   );

   modport fetch (
      input  hit_valid, hit_code, hit_row, hit_x, hit_color, hit_xflip,
      output credit
   );

endinterface

// ==== obj_pkg.sv ====
package obj_pkg;

   // --------------------
   // Vector types
   // --------------------

   // Line buffer pixel as {colour[1:0], pattern[1:0]}
   // Pattern value 0 means transparent
   typedef logic [3:0] obj_pixel_t;

   // Horizontal position or line number
   typedef logic [7:0] obj_pos_t;

   // Pattern code, 32 codes
   typedef logic [4:0] obj_code_t;

   // Row inside an 8-line object
   typedef logic [2:0] obj_row_t;

   // Attribute entry index, 64 objects
   typedef logic [5:0] obj_index_t;

   // CPU bus
   typedef logic [9:0] cpu_addr_t;
   typedef logic [7:0] cpu_data_t;

   // --------------------
   // Address map
   // --------------------

   // Attribute RAM, 4 bytes per entry: Y, code, attribute, X
   localparam cpu_addr_t ATTR_BASE = 10'h000;
   // Control register
   localparam cpu_addr_t CTRL_ADDR = 10'h100;
   // Pattern RAM, 16 bytes per code, plane 0 then plane 1 per row
   localparam cpu_addr_t PAT_BASE  = 10'h200;

   // Control register bits
   localparam int CTRL_EN_BIT   = 0;
   localparam int CTRL_FLIP_BIT = 1;

   // --------------------
   // State machines
   // --------------------
   typedef enum logic [1:0] {SCAN_IDLE, SCAN_READ, SCAN_TEST, SCAN_DONE} scan_state_t;

   typedef enum logic [1:0] {FETCH_IDLE, FETCH_PLANE0, FETCH_PLANE1, FETCH_DRAW} fetch_state_t;

endpackage
